// File: all.f
logic/softmax_pkg.sv
logic/exp_stream_if.sv
logic/vector_fifo.sv
logic/exp_lut.sv
logic/exp_stage.sv
logic/sum_accumulator.sv
logic/normalizer.sv
logic/softmax_top.sv
sim/sim_clock_gen.sv
sim/tb_softmax.sv

// File: logic/exp_lut.sv
`timescale 1ns/1ps

module exp_lut import softmax_pkg::*; (
  input  elem_t x,
  output exp_t  y
);

  typedef exp_t table_t [256];

  // exp(code / 16) * 16, round half up, clip at EXP_MAX
  function automatic exp_t exp_code(input int code);
    real xr;
    real scaled;
    int  q;
    xr     = real'(code) / real'(2 ** FRAC_BITS);
    scaled = $exp(xr) * real'(2 ** FRAC_BITS);
    q      = $rtoi(scaled + ROUND_HALF); // scaled is positive so this floors
    if (q > EXP_MAX) begin
      q = EXP_MAX;
    end
    return exp_t'(q);
  endfunction

  function automatic table_t build_table();
    table_t t;
    for (int i = 0; i < 256; i++) begin
      t[i] = exp_code((i >= 128) ? i - 256 : i); // two's complement code
    end
    return t;
  endfunction

  localparam table_t EXP_TABLE = build_table();

  assign y = EXP_TABLE[$unsigned(x)];

endmodule

// File: logic/exp_stage.sv
`timescale 1ns/1ps

module exp_stage import softmax_pkg::*; #(
  parameter int VEC_LEN = 4
) (
  input  logic         clk,
  input  logic         rst,
  input  elem_t        elem,
  input  logic         elem_valid,
  output logic         elem_ready,
  exp_stream_if.src    to_fifo,
  exp_stream_if.src    to_sum
);

  localparam int IDX_W = $clog2(MAX_VEC_LEN);

  exp_t             lut_y;
  exp_t             data_q;
  logic             last_q;
  logic             full;
  logic             fifo_done; // fifo branch already took the entry
  logic             sum_done;
  logic [IDX_W-1:0] idx;
  logic             fifo_fire;
  logic             sum_fire;
  logic             all_taken;
  logic             load;

  exp_lut i_exp_lut (
    .x (elem),
    .y (lut_y)
  );

  // each branch sees valid until it has taken the entry once
  assign to_fifo.valid = full && !fifo_done;
  assign to_sum.valid  = full && !sum_done;
  assign to_fifo.data  = data_q;
  assign to_fifo.last  = last_q;
  assign to_sum.data   = data_q;
  assign to_sum.last   = last_q;

  assign fifo_fire = to_fifo.valid && to_fifo.ready;
  assign sum_fire  = to_sum.valid && to_sum.ready;
  assign all_taken = (fifo_done || fifo_fire) && (sum_done || sum_fire);

  assign elem_ready = !full || all_taken;
  assign load       = elem_valid && elem_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      full      <= 1'b0;
      fifo_done <= 1'b0;
      sum_done  <= 1'b0;
      idx       <= '0;
    end else if (load) begin
      full      <= 1'b1;
      fifo_done <= 1'b0;
      sum_done  <= 1'b0;
      idx       <= (idx == IDX_W'(VEC_LEN - 1)) ? '0 : idx + 1'b1; // wrap per vector
    end else if (all_taken) begin
      full      <= 1'b0;
      fifo_done <= 1'b0;
      sum_done  <= 1'b0;
    end else begin
      if (fifo_fire) fifo_done <= 1'b1;
      if (sum_fire) sum_done <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      data_q <= lut_y;
      last_q <= (idx == IDX_W'(VEC_LEN - 1));
    end
  end

endmodule

// File: logic/exp_stream_if.sv
`timescale 1ns/1ps

// one exponent per transfer, last marks the end of a vector
interface exp_stream_if
  import softmax_pkg::*;
();

  exp_t data;
  logic last;
  logic valid;
  logic ready;

  modport src (
    output data,
    output last,
    output valid,
    input  ready
  );

  modport dst (
    input  data,
    input  last,
    input  valid,
    output ready
  );

endinterface

// File: logic/normalizer.sv
`timescale 1ns/1ps

module normalizer import softmax_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  exp_stream_if.dst in,
  input  sum_t      sum,
  input  logic      sum_valid,
  output logic      sum_ready,
  output prob_t     out_data,
  output logic      out_valid,
  input  logic      out_ready
);

  // exponent shifted up by FRAC_BITS plus one rounding bit
  localparam int NUM_W = $bits(exp_t) + FRAC_BITS + 1;

  logic             slot_free;
  logic             fire;
  logic [NUM_W-1:0] num;
  logic [NUM_W-1:0] quot;
  logic [NUM_W-1:0] rounded;
  prob_t            result;

  assign slot_free = !out_valid || out_ready;

  // join, both sides move together or not at all
  assign in.ready  = sum_valid && slot_free;
  assign sum_ready = in.valid && slot_free;
  assign fire      = in.valid && sum_valid && slot_free;

  always_comb begin
    num     = NUM_W'(in.data) << (FRAC_BITS + 1);
    quot    = '0;
    rounded = '0;
    result  = '0;
    if (sum != '0) begin
      quot    = num / NUM_W'(sum);
      rounded = (quot + 1'b1) >> 1; // round half up
      if (rounded > NUM_W'(PROB_MAX)) begin
        result = prob_t'(PROB_MAX);
      end else begin
        result = prob_t'(rounded);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (fire) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      out_data <= result;
    end
  end

endmodule

// File: logic/softmax_pkg.sv
package softmax_pkg;

  // fixed point format shared by input, exponent and output
  localparam int FRAC_BITS = 4;
  localparam int MAX_VEC_LEN = 16; // bounds counters and the sum width

  localparam int ELEM_W = 8;
  localparam int EXP_W = 8;
  localparam int SUM_W = EXP_W + $clog2(MAX_VEC_LEN);
  localparam int PROB_W = 8;

  // signed input element, 4 fraction bits
  typedef logic signed [ELEM_W-1:0] elem_t;
  // exp(x) scaled by 2**FRAC_BITS
  typedef logic [EXP_W-1:0] exp_t;
  // sum over one vector, wide enough for MAX_VEC_LEN full-scale terms
  typedef logic [SUM_W-1:0] sum_t;
  typedef logic [PROB_W-1:0] prob_t;

  // saturation limits
  localparam int EXP_MAX = 2 ** EXP_W - 1;
  localparam int PROB_MAX = 2 ** PROB_W - 1;

  // half an lsb, added before truncation in the table build
  localparam real ROUND_HALF = 0.5;

endpackage

// File: logic/softmax_top.sv
`timescale 1ns/1ps

module softmax_top import softmax_pkg::*; #(
  parameter int VEC_LEN = 4
) (
  input  logic  clk,
  input  logic  rst,
  input  elem_t in_data,
  input  logic  in_valid,
  output logic  in_ready,
  output prob_t out_data,
  output logic  out_valid,
  input  logic  out_ready
);

  localparam int EXP_ENTRY_W = $bits(exp_t) + 1; // exponent plus last flag

  elem_t                  buf_elem;
  logic                   buf_valid;
  logic                   buf_ready;
  logic [EXP_ENTRY_W-1:0] exp_wr;
  logic [EXP_ENTRY_W-1:0] exp_rd;
  sum_t                   sum;
  logic                   sum_valid;
  logic                   sum_ready;

  exp_stream_if to_fifo ();
  exp_stream_if to_sum ();
  exp_stream_if from_fifo ();

  vector_fifo #(
    .DEPTH (VEC_LEN),
    .WIDTH ($bits(elem_t))
  ) input_buffer (
    .clk      (clk),
    .rst      (rst),
    .wr_data  (in_data),
    .wr_valid (in_valid),
    .wr_ready (in_ready),
    .rd_data  (buf_elem),
    .rd_valid (buf_valid),
    .rd_ready (buf_ready)
  );

  exp_stage #(
    .VEC_LEN (VEC_LEN)
  ) i_exp_stage (
    .clk        (clk),
    .rst        (rst),
    .elem       (buf_elem),
    .elem_valid (buf_valid),
    .elem_ready (buf_ready),
    .to_fifo    (to_fifo.src),
    .to_sum     (to_sum.src)
  );

  // buffer path holds a whole vector while its sum forms
  assign exp_wr = {to_fifo.last, to_fifo.data};
  assign {from_fifo.last, from_fifo.data} = exp_rd;

  vector_fifo #(
    .DEPTH (VEC_LEN),
    .WIDTH (EXP_ENTRY_W)
  ) exp_buffer (
    .clk      (clk),
    .rst      (rst),
    .wr_data  (exp_wr),
    .wr_valid (to_fifo.valid),
    .wr_ready (to_fifo.ready),
    .rd_data  (exp_rd),
    .rd_valid (from_fifo.valid),
    .rd_ready (from_fifo.ready)
  );

  sum_accumulator #(
    .VEC_LEN (VEC_LEN)
  ) i_sum_accumulator (
    .clk       (clk),
    .rst       (rst),
    .in        (to_sum.dst),
    .sum       (sum),
    .sum_valid (sum_valid),
    .sum_ready (sum_ready)
  );

  normalizer i_normalizer (
    .clk       (clk),
    .rst       (rst),
    .in        (from_fifo.dst),
    .sum       (sum),
    .sum_valid (sum_valid),
    .sum_ready (sum_ready),
    .out_data  (out_data),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

endmodule

// File: logic/sum_accumulator.sv
`timescale 1ns/1ps

module sum_accumulator import softmax_pkg::*; #(
  parameter int VEC_LEN = 4
) (
  input  logic      clk,
  input  logic      rst,
  exp_stream_if.dst in,
  output sum_t      sum,
  output logic      sum_valid,
  input  logic      sum_ready
);

  localparam int CNT_W = $clog2(MAX_VEC_LEN + 1);

  typedef enum logic {
    ACCUM,
    HOLD
  } state_t;

  state_t           state;
  sum_t             acc;
  logic [CNT_W-1:0] reads_left; // reads still owed to the normalizer

  // no new terms while the finished sum is on offer
  assign in.ready  = (state == ACCUM);
  assign sum_valid = (state == HOLD);
  assign sum       = acc;

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= ACCUM;
      acc        <= '0;
      reads_left <= '0;
    end else begin
      case (state)
        ACCUM: begin
          if (in.valid && in.ready) begin
            acc <= acc + sum_t'(in.data);
            if (in.last) begin
              state      <= HOLD;
              reads_left <= CNT_W'(VEC_LEN);
            end
          end
        end
        HOLD: begin
          if (sum_ready) begin
            if (reads_left == CNT_W'(1)) begin
              // last read of this vector, start fresh
              state <= ACCUM;
              acc   <= '0;
            end
            reads_left <= reads_left - 1'b1;
          end
        end
        default: state <= ACCUM;
      endcase
    end
  end

endmodule

// File: logic/vector_fifo.sv
`timescale 1ns/1ps

module vector_fifo #(
  parameter int DEPTH = 4,
  parameter int WIDTH = 8
) (
  input  logic             clk,
  input  logic             rst,
  input  logic [WIDTH-1:0] wr_data,
  input  logic             wr_valid,
  output logic             wr_ready,
  output logic [WIDTH-1:0] rd_data,
  output logic             rd_valid,
  input  logic             rd_ready
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             wr_fire;
  logic             rd_fire;

  assign wr_ready = (count != CNT_W'(DEPTH)); // low only when full
  assign rd_valid = (count != '0);
  assign rd_data  = mem[rd_ptr];

  assign wr_fire = wr_valid && wr_ready;
  assign rd_fire = rd_valid && rd_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_fire) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_fire) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // simultaneous read and write keeps the count
      if (wr_fire && !rd_fire) begin
        count <= count + 1'b1;
      end else if (rd_fire && !wr_fire) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      mem[wr_ptr] <= wr_data;
    end
  end

endmodule

// File: sim/sim_clock_gen.sv
`timescale 1ns/1ps

module sim_clock_gen #(
  parameter int PERIOD_NS  = 10,
  parameter int RST_CYCLES = 8
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2.0) clk = ~clk;
  end

  // release just after an edge, like the rest of the stimulus
  initial begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    #1 rst = 1'b0;
  end

endmodule

// File: sim/tb_softmax.sv
`timescale 1ns/1ps

module tb_softmax import softmax_pkg::*; ();

  localparam int VEC_LEN = 4;
  localparam int NUM_ROWS = 12;
  localparam int WATCHDOG_CYCLES = NUM_ROWS * VEC_LEN * 40 + 200;
  localparam int HOLD_LEN = 40; // cycles of out_ready low in a held stretch

  // out_ready patterns
  localparam int READY_ALWAYS = 0;
  localparam int READY_RANDOM = 1;
  localparam int READY_HOLD   = 2;

  logic  clk;
  logic  rst;
  elem_t in_data;
  logic  in_valid;
  logic  in_ready;
  prob_t out_data;
  logic  out_valid;
  logic  out_ready;

  string row_name [NUM_ROWS];
  int    row_elem [NUM_ROWS][VEC_LEN];
  int    row_mode [NUM_ROWS];

  int    mode = READY_ALWAYS;
  int    exp_q[$];
  string name_q[$];
  int    n_pushed = 0;
  int    n_recv = 0;
  int    data_errors = 0;
  int    other_errors = 0;
  logic  saw_in_ready_low = 1'b0;
  logic  prev_stalled = 1'b0;
  prob_t prev_data;
  int    want;
  string want_name;

  sim_clock_gen #(.PERIOD_NS(10), .RST_CYCLES(8)) i_sim_clock_gen (.clk(clk), .rst(rst));

  softmax_top #(.VEC_LEN(VEC_LEN)) i_softmax_top (
    .clk       (clk),
    .rst       (rst),
    .in_data   (in_data),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_data  (out_data),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  task automatic set_row(input int r, input string name, input int e0, input int e1,
                         input int e2, input int e3, input int m);
    row_name[r] = name;
    row_elem[r][0] = e0;
    row_elem[r][1] = e1;
    row_elem[r][2] = e2;
    row_elem[r][3] = e3;
    row_mode[r] = m;
  endtask

  // exp(code/16)*16, half up, clipped at 255
  function automatic int exp_ref(input int code);
    real scaled;
    int  q;
    scaled = $exp(real'(code) / 16.0) * 16.0;
    q = int'($floor(scaled + 0.5));
    if (q > 255) q = 255;
    return q;
  endfunction

  // floor(16*e/s + 1/2) in integers
  function automatic int prob_ref(input int e, input int s);
    int q;
    if (s == 0) return 0;
    q = (e * 32 + s) / (2 * s);
    if (q > 255) q = 255;
    return q;
  endfunction

  task automatic push_expected(input int r);
    int e [VEC_LEN];
    int s;
    s = 0;
    for (int k = 0; k < VEC_LEN; k++) begin
      e[k] = exp_ref(row_elem[r][k]);
      s += e[k];
    end
    for (int k = 0; k < VEC_LEN; k++) begin
      exp_q.push_back(prob_ref(e[k], s));
      name_q.push_back(row_name[r]);
      n_pushed++;
    end
  endtask

  task automatic send_row(input int r);
    mode = row_mode[r];
    push_expected(r);
    for (int k = 0; k < VEC_LEN; k++) begin
      in_data  = elem_t'(row_elem[r][k]);
      in_valid = 1'b1;
      @(posedge clk);
      while (!in_ready) @(posedge clk);
      #1;
    end
    in_valid = 1'b0;
  endtask

  initial begin
    set_row(0, "mixed", 16, 0, -16, 32, READY_ALWAYS);
    set_row(1, "uniform", 8, 8, 8, 8, READY_ALWAYS);
    set_row(2, "saturated", 127, 127, 127, 127, READY_ALWAYS);
    set_row(3, "all_min", -128, -128, -128, -128, READY_ALWAYS);
    set_row(4, "b2b_a", -48, 40, 5, -3, READY_ALWAYS);
    set_row(5, "b2b_b", 100, -100, 0, 64, READY_ALWAYS);
    set_row(6, "rand_a", 20, -20, 60, -60, READY_RANDOM);
    set_row(7, "rand_b", 7, -7, 3, -3, READY_RANDOM);
    set_row(8, "rand_c", 127, -128, 0, 16, READY_RANDOM);
    set_row(9, "hold_a", 32, 16, 0, -16, READY_HOLD);
    set_row(10, "hold_b", -32, 48, 24, 8, READY_HOLD);
    set_row(11, "hold_c", 0, 0, 16, 16, READY_HOLD);
  end

  // out_ready pattern, follows the row being driven
  initial begin : ready_gen
    int hold_cycles;
    int cur_mode;
    hold_cycles = 0;
    cur_mode = READY_ALWAYS;
    void'($urandom(2)); // one seed for the whole run
    out_ready = 1'b1;
    forever begin
      @(posedge clk);
      cur_mode = mode; // row mode as it stood at the edge
      #1;
      case (cur_mode)
        READY_RANDOM: begin
          out_ready = ($urandom % 4) != 0;
          hold_cycles = 0;
        end
        READY_HOLD: begin
          out_ready = (hold_cycles >= HOLD_LEN);
          hold_cycles++;
        end
        default: begin
          out_ready = 1'b1;
          hold_cycles = 0;
        end
      endcase
    end
  end

  // output monitor
  always @(posedge clk) begin
    if (!rst) begin
      if (mode == READY_HOLD && !in_ready) saw_in_ready_low = 1'b1;
      if (prev_stalled) begin
        assert (out_valid && out_data == prev_data) else begin
          $display("output changed while stalled by out_ready");
          other_errors++;
        end
      end
      prev_stalled = out_valid && !out_ready;
      prev_data = out_data;
      if (out_valid && out_ready) begin
        assert (exp_q.size() > 0) else begin
          $display("unexpected output %0d with nothing pending", out_data);
          other_errors++;
        end
        if (exp_q.size() > 0) begin
          want = exp_q.pop_front();
          want_name = name_q.pop_front();
          n_recv++;
          assert (int'(out_data) == want) else begin
            $display("ERR %s expected %0d actual %0d", want_name, want, out_data);
            data_errors++;
          end
        end
      end
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, %0d of %0d outputs missing",
             WATCHDOG_CYCLES, n_pushed - n_recv, n_pushed);
    $display("Some tests failed");
    $finish;
  end

  initial begin : main
    in_data  = '0;
    in_valid = 1'b0;
    @(negedge rst);
    assert (out_valid === 1'b0) else begin
      $display("out_valid not low after reset");
      other_errors++;
    end
    @(posedge clk);
    #1;
    for (int r = 0; r < NUM_ROWS; r++) begin
      send_row(r);
    end
    mode = READY_ALWAYS; // drain
    while (n_recv < n_pushed) @(posedge clk);
    repeat (20) @(posedge clk); // room for a stray extra output
    assert (saw_in_ready_low) else begin
      $display("in_ready never fell while out_ready was held low");
      other_errors++;
    end
    $display("data errors: %0d, other errors: %0d", data_errors, other_errors);
    if (data_errors == 0 && other_errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule
